// ==== design/ddr_pager_cfg.svh ====
// build-time sizing for the DDR burst mover
// include wherever burst length, bus widths or page counter widths are needed
`ifndef DDR_PAGER_CFG_SVH
`define DDR_PAGER_CFG_SVH

// one burst moves one page
`define DDR_BURST_BEATS 16
`define DDR_BEAT_BYTES  8
// byte step between consecutive pages
`define DDR_PAGE_BYTES  ((`DDR_BURST_BEATS) * (`DDR_BEAT_BYTES))

`define DDR_ADDR_W      32
`define DDR_DATA_W      64
`define DDR_PAGE_CNT_W  32
`define DDR_OFFSET_W    20

`endif

// ==== design/axi_burst_pkg.sv ====
// AXI bus vector types and channel state machines
// shared by the write engine, the read engine and the top level
`default_nettype none
`include "ddr_pager_cfg.svh"

package axi_burst_pkg;

   // byte address on the AXI bus
   typedef logic [`DDR_ADDR_W-1:0] axi_addr_t;
   // one data beat
   typedef logic [`DDR_DATA_W-1:0] axi_data_t;
   // beat index inside a burst
   typedef logic [7:0]             beat_cnt_t;

   // write side: address, data beats, then response
   typedef enum logic [1:0] {wr_idle, wr_addr, wr_data, wr_resp} wr_state_t;

   // read side: address, then data beats up to rlast
   typedef enum logic [1:0] {rd_idle, rd_addr, rd_data} rd_state_t;

endpackage

`default_nettype wire

// ==== design/page_track_pkg.sv ====
// page bookkeeping types for the tracker, the engines and the top level
`default_nettype none
`include "ddr_pager_cfg.svh"

package page_track_pkg;

   // number of pages written or read
   typedef logic [`DDR_PAGE_CNT_W-1:0] page_cnt_t;

   // first page of the memory window
   typedef logic [`DDR_OFFSET_W-1:0]   mem_offset_t;

endpackage

`default_nettype wire

// ==== design/axi_write_engine.sv ====
// AXI4 burst write engine, one page per write command
// the source FIFO head is the write data and pops on every accepted beat
`timescale 1ns/1ps
`default_nettype none
`include "ddr_pager_cfg.svh"

module axi_write_engine
   import axi_burst_pkg::*;
   import page_track_pkg::*;
(
   input  wire              sysclk_i,
   input  wire              reset,
   // command and tracker status
   input  wire              write_mem_i,
   input  wire              ddr_full_i,
   input  wire page_cnt_t   wr_page_i,
   input  wire mem_offset_t mem_start_i,
   // source FIFO, first word fall through
   input  wire              fifo_empty_i,
   input  wire axi_data_t   fifo_data_i,
   output logic             fifo_re_o,
   // AXI write address
   output axi_addr_t        awaddr_o,
   output logic             awvalid_o,
   input  wire              awready_i,
   // AXI write data
   output axi_data_t        wdata_o,
   output logic             wlast_o,
   output logic             wvalid_o,
   input  wire              wready_i,
   // AXI write response, bready tied high outside
   input  wire              bvalid_i,
   // strobes to the page tracker
   output logic             wr_start_o,
   output logic             wr_done_o
);

   wr_state_t state;
   beat_cnt_t beat_cnt;
   axi_addr_t page_sum;
   logic      accept;
   logic      last_beat;

   // command only taken when idle and memory has room
   assign accept    = (state == wr_idle) && write_mem_i && !ddr_full_i;
   assign last_beat = (beat_cnt == beat_cnt_t'(`DDR_BURST_BEATS - 1));
   // page index of this burst inside the whole memory
   assign page_sum  = axi_addr_t'(mem_start_i) + axi_addr_t'(wr_page_i);

   ////////////////////////////////////////////////////////////////////////////
   // data channel, straight from the FIFO head
   ////////////////////////////////////////////////////////////////////////////

   // an empty FIFO drops wvalid, no beat is lost
   assign wvalid_o   = (state == wr_data) && !fifo_empty_i;
   assign wdata_o    = fifo_data_i;
   assign wlast_o    = (state == wr_data) && last_beat;
   // pop exactly on the beat handshake
   assign fifo_re_o  = wvalid_o && wready_i;
   assign wr_start_o = accept;

   ////////////////////////////////////////////////////////////////////////////
   // burst sequencing
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge sysclk_i or posedge reset)
   begin
      if (reset)
      begin
         state     <= wr_idle;
         awvalid_o <= 1'b0;
         beat_cnt  <= '0;
         wr_done_o <= 1'b0;
      end
      else
      begin
         // done is a single cycle pulse
         wr_done_o <= 1'b0;
         case (state)
            wr_idle:
            begin
               if (accept)
               begin
                  awvalid_o <= 1'b1;
                  state     <= wr_addr;
               end
            end
            wr_addr:
            begin
               // hold awvalid until the slave takes it
               if (awready_i)
               begin
                  awvalid_o <= 1'b0;
                  beat_cnt  <= '0;
                  state     <= wr_data;
               end
            end
            wr_data:
            begin
               if (fifo_re_o)
               begin
                  beat_cnt <= beat_cnt + 1'b1;
                  if (last_beat)
                     state <= wr_resp;
               end
            end
            wr_resp:
            begin
               if (bvalid_i)
               begin
                  wr_done_o <= 1'b1;
                  state     <= wr_idle;
               end
            end
            default:
               state <= wr_idle;
         endcase
      end
   end

   // page address latched with the command
   always_ff @(posedge sysclk_i)
   begin
      if (accept)
         awaddr_o <= axi_addr_t'(page_sum * `DDR_PAGE_BYTES);
   end

endmodule

`default_nettype wire

// ==== design/axi_read_engine.sv ====
// AXI4 burst read engine, one page per read command
// every returned beat is written into the sink FIFO one cycle later
`timescale 1ns/1ps
`default_nettype none
`include "ddr_pager_cfg.svh"

module axi_read_engine
   import axi_burst_pkg::*;
   import page_track_pkg::*;
(
   input  wire              sysclk_i,
   input  wire              reset,
   // command and page position
   input  wire              read_mem_i,
   input  wire page_cnt_t   rd_page_i,
   input  wire mem_offset_t mem_start_i,
   // AXI read address
   output axi_addr_t        araddr_o,
   output logic             arvalid_o,
   input  wire              arready_i,
   // AXI read data
   input  wire axi_data_t   rdata_i,
   input  wire              rlast_i,
   input  wire              rvalid_i,
   output logic             rready_o,
   // sink FIFO, never pushes back
   output axi_data_t        mem_data_o,
   output logic             mem_we_o,
   // strobes to the page tracker
   output logic             rd_start_o,
   output logic             rd_done_o
);

   rd_state_t state;
   axi_addr_t page_sum;
   logic      accept;
   logic      beat_in;

   // a command while busy is dropped
   assign accept     = (state == rd_idle) && read_mem_i;
   assign page_sum   = axi_addr_t'(mem_start_i) + axi_addr_t'(rd_page_i);
   // always ready during the data phase
   assign rready_o   = (state == rd_data);
   assign beat_in    = rready_o && rvalid_i;
   assign rd_start_o = accept;

   ////////////////////////////////////////////////////////////////////////////
   // burst sequencing
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge sysclk_i or posedge reset)
   begin
      if (reset)
      begin
         state     <= rd_idle;
         arvalid_o <= 1'b0;
         mem_we_o  <= 1'b0;
         rd_done_o <= 1'b0;
      end
      else
      begin
         // sink write follows each accepted beat
         mem_we_o  <= beat_in;
         rd_done_o <= 1'b0;
         case (state)
            rd_idle:
            begin
               if (accept)
               begin
                  arvalid_o <= 1'b1;
                  state     <= rd_addr;
               end
            end
            rd_addr:
            begin
               if (arready_i)
               begin
                  arvalid_o <= 1'b0;
                  state     <= rd_data;
               end
            end
            rd_data:
            begin
               // burst ends on the beat marked last
               if (beat_in && rlast_i)
               begin
                  rd_done_o <= 1'b1;
                  state     <= rd_idle;
               end
            end
            default:
               state <= rd_idle;
         endcase
      end
   end

   // address and sink data are plain payload
   always_ff @(posedge sysclk_i)
   begin
      if (accept)
         araddr_o <= axi_addr_t'(page_sum * `DDR_PAGE_BYTES);
      if (beat_in)
         mem_data_o <= rdata_i;
   end

endmodule

`default_nettype wire

// ==== design/page_tracker.sv ====
// counts pages written and read, flags the last page and a full memory
// clears itself once the last written page has been read back
`timescale 1ns/1ps
`default_nettype none

module page_tracker
   import page_track_pkg::*;
(
   input  wire            sysclk_i,
   input  wire            reset,
   // pages to hold before memory counts as full
   input  wire page_cnt_t page_limit_i,
   // engine strobes
   input  wire            wr_start_i,
   input  wire            wr_done_i,
   input  wire            rd_start_i,
   input  wire            rd_done_i,
   // status
   output page_cnt_t      wr_pages_o,
   output page_cnt_t      rd_pages_o,
   output logic           last_write_o,
   output logic           ddr_full_o
);

   page_cnt_t wr_pages_d;
   logic      restart;

   // last written page has just been read back
   assign restart    = rd_done_i && (rd_pages_o == page_limit_i);
   // next write count, so last_write moves together with the count
   assign wr_pages_d = restart ? '0 : wr_pages_o + page_cnt_t'(wr_start_i);

   always_ff @(posedge sysclk_i or posedge reset)
   begin
      if (reset)
      begin
         wr_pages_o   <= '0;
         rd_pages_o   <= '0;
         last_write_o <= 1'b0;
         ddr_full_o   <= 1'b0;
      end
      else
      begin
         wr_pages_o   <= wr_pages_d;
         last_write_o <= (wr_pages_d == page_limit_i);
         // read count steps at the start of each read
         if (restart)
            rd_pages_o <= '0;
         else if (rd_start_i)
            rd_pages_o <= rd_pages_o + 1'b1;
         // full once the last page write has completed
         if (restart)
            ddr_full_o <= 1'b0;
         else if (wr_done_i && last_write_o)
            ddr_full_o <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== design/ddr_pager.sv ====
// top level of the FIFO to DDR burst mover
// write and read engines run side by side, the tracker joins their strobes
`timescale 1ns/1ps
`default_nettype none

module ddr_pager
   import axi_burst_pkg::*;
   import page_track_pkg::*;
(
   input  wire              sysclk_i,
   input  wire              reset,
   // control
   input  wire              write_mem_i,
   input  wire              read_mem_i,
   input  wire mem_offset_t mem_start_i,
   input  wire page_cnt_t   page_limit_i,
   // status
   output logic             write_done_o,
   output logic             read_done_o,
   output logic             ddr_full_o,
   output logic             last_write_o,
   output page_cnt_t        wr_pages_o,
   output page_cnt_t        rd_pages_o,
   // source and sink FIFOs
   input  wire              fifo_empty_i,
   input  wire axi_data_t   fifo_data_i,
   output logic             fifo_re_o,
   output axi_data_t        mem_data_o,
   output logic             mem_we_o,
   // AXI write channels
   output axi_addr_t        awaddr_o,
   output logic             awvalid_o,
   input  wire              awready_i,
   output axi_data_t        wdata_o,
   output logic             wlast_o,
   output logic             wvalid_o,
   input  wire              wready_i,
   input  wire              bvalid_i,
   // AXI read channels
   output axi_addr_t        araddr_o,
   output logic             arvalid_o,
   input  wire              arready_i,
   input  wire axi_data_t   rdata_i,
   input  wire              rlast_i,
   input  wire              rvalid_i,
   output logic             rready_o
);

   // command accepted strobes into the tracker
   logic wr_start;
   logic rd_start;

   axi_write_engine u_write (
      .sysclk_i    (sysclk_i),
      .reset       (reset),
      .write_mem_i (write_mem_i),
      .ddr_full_i  (ddr_full_o),
      .wr_page_i   (wr_pages_o),
      .mem_start_i (mem_start_i),
      .fifo_empty_i(fifo_empty_i),
      .fifo_data_i (fifo_data_i),
      .fifo_re_o   (fifo_re_o),
      .awaddr_o    (awaddr_o),
      .awvalid_o   (awvalid_o),
      .awready_i   (awready_i),
      .wdata_o     (wdata_o),
      .wlast_o     (wlast_o),
      .wvalid_o    (wvalid_o),
      .wready_i    (wready_i),
      .bvalid_i    (bvalid_i),
      .wr_start_o  (wr_start),
      .wr_done_o   (write_done_o)
   );

   axi_read_engine u_read (
      .sysclk_i    (sysclk_i),
      .reset       (reset),
      .read_mem_i  (read_mem_i),
      .rd_page_i   (rd_pages_o),
      .mem_start_i (mem_start_i),
      .araddr_o    (araddr_o),
      .arvalid_o   (arvalid_o),
      .arready_i   (arready_i),
      .rdata_i     (rdata_i),
      .rlast_i     (rlast_i),
      .rvalid_i    (rvalid_i),
      .rready_o    (rready_o),
      .mem_data_o  (mem_data_o),
      .mem_we_o    (mem_we_o),
      .rd_start_o  (rd_start),
      .rd_done_o   (read_done_o)
   );

   // page counts feed back as the engines' page addresses
   page_tracker u_track (
      .sysclk_i    (sysclk_i),
      .reset       (reset),
      .page_limit_i(page_limit_i),
      .wr_start_i  (wr_start),
      .wr_done_i   (write_done_o),
      .rd_start_i  (rd_start),
      .rd_done_i   (read_done_o),
      .wr_pages_o  (wr_pages_o),
      .rd_pages_o  (rd_pages_o),
      .last_write_o(last_write_o),
      .ddr_full_o  (ddr_full_o)
   );

endmodule

`default_nettype wire

// ==== dv/ddr_pager_properties.sv ====
// bound protocol checks for the DDR burst mover
// attached to every ddr_pager instance from the testbench
`timescale 1ns/1ps
`default_nettype none
`include "ddr_pager_cfg.svh"

module ddr_pager_properties
   import axi_burst_pkg::*;
(
   input wire            sysclk_i,
   input wire            reset,
   input wire axi_addr_t awaddr_o,
   input wire            awvalid_o,
   input wire            awready_i,
   input wire axi_data_t wdata_o,
   input wire            wlast_o,
   input wire            wvalid_o,
   input wire            wready_i,
   input wire axi_addr_t araddr_o,
   input wire            arvalid_o,
   input wire            arready_i,
   input wire            fifo_re_o,
   input wire            fifo_empty_i
);

   // index of the next write beat inside the burst
   beat_cnt_t   beats;
   // failed assertions so far, read by the testbench at the end
   int unsigned fail_cnt = 0;

   always_ff @(posedge sysclk_i or posedge reset)
   begin
      if (reset)
         beats <= '0;
      else if (wvalid_o && wready_i)
         beats <= wlast_o ? beat_cnt_t'(0) : beats + beat_cnt_t'(1);
   end

   ////////////////////////////////////////////////////////////////////////////
   // valid holds with steady payload until ready
   ////////////////////////////////////////////////////////////////////////////

   aw_hold: assert property (@(posedge sysclk_i) disable iff (reset)
      awvalid_o && !awready_i |=> awvalid_o && $stable(awaddr_o))
      else
      begin
         fail_cnt++;
         $error("awvalid_o or awaddr_o changed before awready_i");
      end

   w_hold: assert property (@(posedge sysclk_i) disable iff (reset)
      wvalid_o && !wready_i |=> wvalid_o && $stable(wdata_o))
      else
      begin
         fail_cnt++;
         $error("wvalid_o or wdata_o changed before wready_i");
      end

   ar_hold: assert property (@(posedge sysclk_i) disable iff (reset)
      arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o))
      else
      begin
         fail_cnt++;
         $error("arvalid_o or araddr_o changed before arready_i");
      end

   // wlast on the final beat and nowhere else
   w_last: assert property (@(posedge sysclk_i) disable iff (reset)
      wvalid_o |-> (wlast_o == (beats == beat_cnt_t'(`DDR_BURST_BEATS - 1))))
      else
      begin
         fail_cnt++;
         $error("wlast_o does not match beat %0d", beats);
      end

   // never pop an empty source FIFO
   fifo_pop: assert property (@(posedge sysclk_i) disable iff (reset)
      fifo_re_o |-> !fifo_empty_i)
      else
      begin
         fail_cnt++;
         $error("fifo_re_o while fifo_empty_i is high");
      end

endmodule

`default_nettype wire

// ==== dv/ddr_pager_tb.sv ====
// directed testbench for the DDR burst mover
// models the source FIFO and an AXI memory with random stalls
// every page is checked end to end
`timescale 1ns/1ps
`default_nettype none
`include "ddr_pager_cfg.svh"

module ddr_pager_tb
   import axi_burst_pkg::*;
   import page_track_pkg::*;
;

   localparam int BEATS     = `DDR_BURST_BEATS;
   localparam int MEM_WORDS = 256;
   localparam int MEM_START = 3;
   localparam int LIMIT     = 2;
   localparam int TIMEOUT   = 400;

   logic        sysclk_i;
   logic        reset;
   logic        write_mem_i;
   logic        read_mem_i;
   mem_offset_t mem_start_i;
   page_cnt_t   page_limit_i;
   logic        write_done_o;
   logic        read_done_o;
   logic        ddr_full_o;
   logic        last_write_o;
   page_cnt_t   wr_pages_o;
   page_cnt_t   rd_pages_o;
   logic        fifo_empty_i;
   axi_data_t   fifo_data_i;
   logic        fifo_re_o;
   axi_data_t   mem_data_o;
   logic        mem_we_o;
   axi_addr_t   awaddr_o;
   logic        awvalid_o;
   logic        awready_i;
   axi_data_t   wdata_o;
   logic        wlast_o;
   logic        wvalid_o;
   logic        wready_i;
   logic        bvalid_i;
   axi_addr_t   araddr_o;
   logic        arvalid_o;
   logic        arready_i;
   axi_data_t   rdata_i;
   logic        rlast_i;
   logic        rvalid_i;
   logic        rready_o;

   // memory model with source FIFO contents and words seen at the sink
   axi_data_t   mem [MEM_WORDS];
   axi_data_t   src_q[$];
   axi_data_t   sink_q[$];
   axi_data_t   page0_words[$];
   axi_data_t   page1_words[$];
   axi_data_t   new_words[$];
   axi_addr_t   last_awaddr;
   axi_addr_t   last_araddr;
   int          wr_ptr;
   int          rd_ptr;
   int          rd_left;
   int          w_beats;
   logic        b_pending;
   logic [15:0] lfsr_state;
   int          errors;
   int          checks;

   ddr_pager u_dut (.*);

   bind ddr_pager ddr_pager_properties u_props (
      .sysclk_i    (sysclk_i),
      .reset       (reset),
      .awaddr_o    (awaddr_o),
      .awvalid_o   (awvalid_o),
      .awready_i   (awready_i),
      .wdata_o     (wdata_o),
      .wlast_o     (wlast_o),
      .wvalid_o    (wvalid_o),
      .wready_i    (wready_i),
      .araddr_o    (araddr_o),
      .arvalid_o   (arvalid_o),
      .arready_i   (arready_i),
      .fifo_re_o   (fifo_re_o),
      .fifo_empty_i(fifo_empty_i)
   );

   initial
   begin
      sysclk_i = 1'b0;
      forever #2 sysclk_i = ~sysclk_i;
   end

   ////////////////////////////////////////////////////////////////////////////
   // helpers
   ////////////////////////////////////////////////////////////////////////////

   // taps of x^16 + x^14 + x^13 + x^11
   // one step per bit taken
   function automatic logic [31:0] lfsr_bits(input int count);
      logic [31:0] val;
      logic        fb;
      val = '0;
      for (int i = 0; i < count; i++)
      begin
         fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
         lfsr_state = {lfsr_state[14:0], fb};
         val        = {val[30:0], fb};
      end
      return val;
   endfunction

   function automatic int word_index(input axi_addr_t addr);
      return int'(addr / `DDR_BEAT_BYTES) % MEM_WORDS;
   endfunction

   // pages sit back to back from mem_start
   function automatic axi_addr_t page_addr(input int page);
      return axi_addr_t'((MEM_START + page) * `DDR_PAGE_BYTES);
   endfunction

   task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
      end
   endtask

   // memory responder with ready stalls and in order read beats
   task automatic drive_bus();
      fifo_empty_i = (src_q.size() == 0);
      fifo_data_i  = (src_q.size() > 0) ? src_q[0] : '0;
      awready_i    = |lfsr_bits(2);
      wready_i     = |lfsr_bits(2);
      arready_i    = |lfsr_bits(2);
      // single cycle response as bready is always high
      if (bvalid_i)
         bvalid_i = 1'b0;
      else if (b_pending)
      begin
         bvalid_i  = 1'b1;
         b_pending = 1'b0;
      end
      if (rd_left > 0 && |lfsr_bits(2))
      begin
         rvalid_i = 1'b1;
         rdata_i  = mem[rd_ptr];
         rlast_i  = (rd_left == 1);
      end
      else
      begin
         rvalid_i = 1'b0;
         rlast_i  = 1'b0;
      end
   endtask

   task automatic step();
      @(negedge sysclk_i);
      drive_bus();
   endtask

   task automatic load_words(input int count, ref axi_data_t exp_q[$]);
      axi_data_t word;
      for (int i = 0; i < count; i++)
      begin
         word = {lfsr_bits(32), lfsr_bits(32)};
         src_q.push_back(word);
         exp_q.push_back(word);
      end
   endtask

   task automatic send_write();
      write_mem_i = 1'b1;
      step();
      write_mem_i = 1'b0;
   endtask

   task automatic send_read();
      read_mem_i = 1'b1;
      step();
      read_mem_i = 1'b0;
   endtask

   function automatic logic watched(input int which);
      case (which)
         0: return write_done_o;
         1: return read_done_o;
         default: return (src_q.size() == 0);
      endcase
   endfunction

   task automatic wait_for(input int which, input string what);
      int n;
      n = 0;
      while (!watched(which) && n < TIMEOUT)
      begin
         step();
         n++;
      end
      if (!watched(which))
      begin
         errors++;
         $display("timeout after %0d cycles waiting for %s", TIMEOUT, what);
      end
   endtask

   task automatic check_memory(input axi_addr_t base, input axi_data_t exp_q[$]);
      int idx;
      idx = word_index(base);
      foreach (exp_q[i])
         check_val($sformatf("mem[%0d]", (idx + i) % MEM_WORDS),
                   mem[(idx + i) % MEM_WORDS], exp_q[i]);
   endtask

   task automatic check_sink(input axi_data_t exp_q[$]);
      check_val("sink word count", 64'(sink_q.size()), 64'(exp_q.size()));
      if (sink_q.size() == exp_q.size())
      begin
         foreach (exp_q[i])
            check_val($sformatf("mem_data_o beat %0d", i), sink_q[i], exp_q[i]);
      end
      sink_q.delete();
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // bus monitor sampling handshakes at the clock edge
   ////////////////////////////////////////////////////////////////////////////

   always @(posedge sysclk_i)
   begin
      if (!reset)
      begin
         if (awvalid_o && awready_i)
         begin
            last_awaddr = awaddr_o;
            wr_ptr      = word_index(awaddr_o);
            w_beats     = 0;
         end
         if (wvalid_o && wready_i)
         begin
            mem[wr_ptr] = wdata_o;
            wr_ptr      = (wr_ptr + 1) % MEM_WORDS;
            w_beats++;
            if (w_beats == BEATS)
               b_pending = 1'b1;
         end
         if (fifo_re_o && src_q.size() > 0)
            void'(src_q.pop_front());
         if (arvalid_o && arready_i)
         begin
            last_araddr = araddr_o;
            rd_ptr      = word_index(araddr_o);
            rd_left     = BEATS;
         end
         if (rvalid_i && rready_o)
         begin
            rd_ptr = (rd_ptr + 1) % MEM_WORDS;
            rd_left--;
         end
         if (mem_we_o)
            sink_q.push_back(mem_data_o);
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // directed tests
   ////////////////////////////////////////////////////////////////////////////

   task automatic check_reset_state();
      check_val("awvalid_o", 64'(awvalid_o), 64'(0));
      check_val("wvalid_o", 64'(wvalid_o), 64'(0));
      check_val("arvalid_o", 64'(arvalid_o), 64'(0));
      check_val("fifo_re_o", 64'(fifo_re_o), 64'(0));
      check_val("mem_we_o", 64'(mem_we_o), 64'(0));
      check_val("write_done_o", 64'(write_done_o), 64'(0));
      check_val("read_done_o", 64'(read_done_o), 64'(0));
      check_val("ddr_full_o", 64'(ddr_full_o), 64'(0));
      check_val("last_write_o", 64'(last_write_o), 64'(0));
      check_val("wr_pages_o", 64'(wr_pages_o), 64'(0));
      check_val("rd_pages_o", 64'(rd_pages_o), 64'(0));
   endtask

   task automatic write_first_page();
      load_words(BEATS, page0_words);
      send_write();
      wait_for(0, "write_done_o on the first page");
      check_val("awaddr_o", 64'(last_awaddr), 64'(page_addr(0)));
      check_memory(page_addr(0), page0_words);
      check_val("wr_pages_o", 64'(wr_pages_o), 64'(1));
      check_val("last_write_o", 64'(last_write_o), 64'(0));
   endtask

   task automatic read_first_page();
      send_read();
      wait_for(1, "read_done_o on the first page");
      // last sink word lands with the done pulse
      step();
      check_val("araddr_o", 64'(last_araddr), 64'(page_addr(0)));
      check_sink(page0_words);
      check_val("rd_pages_o", 64'(rd_pages_o), 64'(1));
   endtask

   task automatic write_with_gap();
      load_words(6, page1_words);
      send_write();
      wait_for(2, "source FIFO to drain");
      // FIFO runs dry mid burst
      repeat (8)
      begin
         step();
         check_val("write_done_o", 64'(write_done_o), 64'(0));
      end
      load_words(BEATS - 6, page1_words);
      wait_for(0, "write_done_o after the FIFO refill");
      check_val("awaddr_o", 64'(last_awaddr), 64'(page_addr(1)));
      check_memory(page_addr(1), page1_words);
      check_val("write beats", 64'(w_beats), 64'(BEATS));
      check_val("source FIFO words left", 64'(src_q.size()), 64'(0));
   endtask

   task automatic write_when_full();
      step();
      check_val("last_write_o", 64'(last_write_o), 64'(1));
      check_val("ddr_full_o", 64'(ddr_full_o), 64'(1));
      load_words(BEATS, new_words);
      send_write();
      // a taken command would raise awvalid right after the strobe
      repeat (TIMEOUT)
      begin
         if (awvalid_o)
         begin
            errors++;
            $display("write address issued at %0t although memory is full", $time);
         end
         step();
      end
      checks++;
      check_val("wr_pages_o", 64'(wr_pages_o), 64'(2));
      src_q.delete();
      new_words.delete();
   endtask

   task automatic drain_and_restart();
      send_read();
      wait_for(1, "read_done_o on the second page");
      step();
      check_val("araddr_o", 64'(last_araddr), 64'(page_addr(1)));
      check_sink(page1_words);
      check_val("ddr_full_o", 64'(ddr_full_o), 64'(0));
      check_val("last_write_o", 64'(last_write_o), 64'(0));
      check_val("wr_pages_o", 64'(wr_pages_o), 64'(0));
      check_val("rd_pages_o", 64'(rd_pages_o), 64'(0));
      // fresh write starts again at page 0
      load_words(BEATS, new_words);
      send_write();
      wait_for(0, "write_done_o after the restart");
      check_val("awaddr_o", 64'(last_awaddr), 64'(page_addr(0)));
      check_memory(page_addr(0), new_words);
      check_val("wr_pages_o", 64'(wr_pages_o), 64'(1));
   endtask

   initial
   begin
      lfsr_state   = 16'd26909;
      errors       = 0;
      checks       = 0;
      reset        = 1'b1;
      write_mem_i  = 1'b0;
      read_mem_i   = 1'b0;
      mem_start_i  = mem_offset_t'(MEM_START);
      page_limit_i = page_cnt_t'(LIMIT);
      fifo_empty_i = 1'b1;
      fifo_data_i  = '0;
      awready_i    = 1'b0;
      wready_i     = 1'b0;
      bvalid_i     = 1'b0;
      arready_i    = 1'b0;
      rdata_i      = '0;
      rlast_i      = 1'b0;
      rvalid_i     = 1'b0;
      b_pending    = 1'b0;
      wr_ptr       = 0;
      rd_ptr       = 0;
      rd_left      = 0;
      w_beats      = 0;
      // background pattern built from every address bit
      for (int i = 0; i < MEM_WORDS; i++)
         mem[i] = {32'(i) ^ 32'h5a0f_3c96, ~32'(i)};
      repeat (10) @(negedge sysclk_i);
      reset = 1'b0;
      step();
      check_reset_state();
      write_first_page();
      read_first_page();
      write_with_gap();
      write_when_full();
      drain_and_restart();
      $display("checks: %0d, errors: %0d, assertion failures: %0d",
               checks, errors, u_dut.u_props.fail_cnt);
      if (errors == 0 && u_dut.u_props.fail_cnt == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+design
design/axi_burst_pkg.sv
design/page_track_pkg.sv
design/axi_write_engine.sv
design/axi_read_engine.sv
design/page_tracker.sv
design/ddr_pager.sv
dv/ddr_pager_properties.sv
dv/ddr_pager_tb.sv

// ==== Makefile ====
# Verilator build and run of the DDR burst mover testbench

TOP := ddr_pager_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		-f tb.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
